// ==== Bender.yml ====
package:
  name: vec_unit

sources:
  - vec_pkg.sv
  - vec_bank.sv
  - vec_vrf.sv
  - vec_decode.sv
  - vec_execute.sv
  - vec_result.sv
  - vec_unit_top.sv
  - target: test
    files:
      - tb_vec_unit.sv

// ==== tb_vec_unit.sv ====
////////////////////////////////////////
// Testbench for the vector unit top with
// a register file model, stimulus tasks
// and concurrent checks
////////////////////////////////////////

`timescale 1ns/1ps

module tb_vec_unit import vec_pkg::*; ();

  // Rough cycle budget of all phases
  localparam int PlannedCycles = 10 + 3 * 32 + 6 * 13 + 3 * 12 + 13 + 2 * 4 + 2 * 32 + 9 + 32;
  localparam int TimeoutCycles = 4 * PlannedCycles;

  logic               clk;
  logic               rst_ni;
  logic               req_i;
  logic               ack_o;
  logic [OpWidth-1:0] op_i;
  vreg_idx_t          vd_i;
  vreg_idx_t          vs1_i;
  vreg_idx_t          vs2_i;
  vl_t                vl_i;
  logic               ext_we_i;
  vaddr_t             ext_waddr_i;
  elem_t              ext_wdata_i;
  be_t                ext_wbe_i;
  logic               ext_wgnt_o;
  logic               ext_re_i;
  vaddr_t             ext_raddr_i;
  elem_t              ext_rdata_o;
  logic               ext_rvalid_o;

  // Expected values set together with the inputs
  logic  exp_ack;
  logic  chk_rd;
  logic  exp_rvalid;
  elem_t exp_rdata;
  logic  chk_wr;
  logic  exp_wgnt;

  elem_t       model [NrVregs][NrElems];
  logic [31:0] rng_state;
  int          errors;
  int          checks;
  int          cycles;

  vec_unit_top uut (
    .clk          (clk),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .ack_o        (ack_o),
    .op_i         (op_i),
    .vd_i         (vd_i),
    .vs1_i        (vs1_i),
    .vs2_i        (vs2_i),
    .vl_i         (vl_i),
    .ext_we_i     (ext_we_i),
    .ext_waddr_i  (ext_waddr_i),
    .ext_wdata_i  (ext_wdata_i),
    .ext_wbe_i    (ext_wbe_i),
    .ext_wgnt_o   (ext_wgnt_o),
    .ext_re_i     (ext_re_i),
    .ext_raddr_i  (ext_raddr_i),
    .ext_rdata_o  (ext_rdata_o),
    .ext_rvalid_o (ext_rvalid_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    cycles = 0;
    while (cycles < TimeoutCycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
    $display("Test failures found");
    $finish;
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  ack_timing: assert property (@(posedge clk) disable iff (!rst_ni) ack_o == exp_ack)
    else begin
      errors++;
      $display("** Error: ack_o = %h, expected %h", $sampled(ack_o), $sampled(exp_ack));
    end

  rd_valid: assert property (@(posedge clk) disable iff (!rst_ni)
                             chk_rd |-> ext_rvalid_o == exp_rvalid)
    else begin
      errors++;
      $display("** Error: ext_rvalid_o = %h, expected %h",
               $sampled(ext_rvalid_o), $sampled(exp_rvalid));
    end

  rd_data: assert property (@(posedge clk) disable iff (!rst_ni)
                            (chk_rd && exp_rvalid) |-> ext_rdata_o == exp_rdata)
    else begin
      errors++;
      $display("** Error: ext_rdata_o = %h, expected %h at address %h",
               $sampled(ext_rdata_o), $sampled(exp_rdata), $sampled(ext_raddr_i));
    end

  wr_grant: assert property (@(posedge clk) disable iff (!rst_ni)
                             chk_wr |-> ext_wgnt_o == exp_wgnt)
    else begin
      errors++;
      $display("** Error: ext_wgnt_o = %h, expected %h",
               $sampled(ext_wgnt_o), $sampled(exp_wgnt));
    end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // vs2 is the left operand and mul keeps the low word
  function automatic elem_t alu_ref(logic [2:0] op, elem_t a, elem_t b);
    case (op)
      3'd0:    return a + b;
      3'd1:    return a - b;
      3'd2:    return a & b;
      3'd3:    return a | b;
      3'd4:    return a ^ b;
      default: return a * b;
    endcase
  endfunction

  task automatic ext_write(input vaddr_t addr, input elem_t data, input be_t be);
    ext_we_i    = 1'b1;
    ext_waddr_i = addr;
    ext_wdata_i = data;
    ext_wbe_i   = be;
    chk_wr      = 1'b1;
    exp_wgnt    = 1'b1;
    checks++;
    @(posedge clk);
    #10;
    ext_we_i = 1'b0;
    chk_wr   = 1'b0;
    for (int b = 0; b < ElemBytes; b++) begin
      if (be[b]) begin
        model[addr[4:2]][addr[1:0]][8*b +: 8] = data[8*b +: 8];
      end
    end
  endtask

  task automatic read_check(input vaddr_t addr);
    ext_re_i    = 1'b1;
    ext_raddr_i = addr;
    chk_rd      = 1'b1;
    exp_rvalid  = 1'b1;
    exp_rdata   = model[addr[4:2]][addr[1:0]];
    checks++;
    @(posedge clk);
    #10;
    ext_re_i = 1'b0;
    chk_rd   = 1'b0;
  endtask

  task automatic check_reg(input vreg_idx_t r);
    for (int k = 0; k < NrElems; k++) begin
      read_check({r, elem_idx_t'(k)});
    end
  endtask

  task automatic check_all();
    for (int r = 0; r < NrVregs; r++) begin
      check_reg(vreg_idx_t'(r));
    end
  endtask

  // Issues one instruction and follows the four-phase handshake.
  // With contend set, the external ports hit the busy banks in cycle 2
  task automatic run_instr(input logic [2:0] op, input vreg_idx_t vd, input vreg_idx_t vs1,
                           input vreg_idx_t vs2, input vl_t vl, input int hold,
                           input bit contend);
    elem_t res [NrElems];
    bit    legal;
    int    lat;
    int    cyc;
    legal = (op <= 3'd5);
    lat   = legal ? int'(vl) + 3 : 1;
    for (int k = 0; k < NrElems; k++) begin
      res[k] = alu_ref(op, model[vs2][k], model[vs1][k]);
    end
    req_i = 1'b1;
    op_i  = op;
    vd_i  = vd;
    vs1_i = vs1;
    vs2_i = vs2;
    vl_i  = vl;
    checks++;
    cyc = -1;
    do begin
      @(posedge clk);
      #10;
      cyc++;
      exp_ack  = (cyc >= lat);
      ext_we_i = 1'b0;
      ext_re_i = 1'b0;
      chk_wr   = 1'b0;
      chk_rd   = 1'b0;
      // Result writes bank 0 while vs1 reads bank 1
      if (contend && cyc == 2) begin
        ext_we_i    = 1'b1;
        ext_waddr_i = {vd ^ 3'd1, 2'd0};
        ext_wdata_i = next_rand();
        ext_wbe_i   = 4'hf;
        chk_wr      = 1'b1;
        exp_wgnt    = 1'b0;
        ext_re_i    = 1'b1;
        ext_raddr_i = {vs2, 2'd1};
        chk_rd      = 1'b1;
        exp_rvalid  = 1'b0;
        checks += 2;
      end
    end while (!ack_o);
    repeat (hold) begin
      @(posedge clk);
      #10;
    end
    req_i = 1'b0;
    @(posedge clk);
    #10;
    exp_ack = 1'b0;
    if (legal) begin
      for (int k = 0; k < int'(vl); k++) begin
        model[vd][k] = res[k];
      end
    end
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    logic [31:0] pick;
    rng_state   = 32'h1dea;
    errors      = 0;
    checks      = 0;
    rst_ni      = 1'b0;
    req_i       = 1'b0;
    op_i        = '0;
    vd_i        = '0;
    vs1_i       = '0;
    vs2_i       = '0;
    vl_i        = '0;
    ext_we_i    = 1'b0;
    ext_waddr_i = '0;
    ext_wdata_i = '0;
    ext_wbe_i   = '0;
    ext_re_i    = 1'b0;
    ext_raddr_i = '0;
    exp_ack     = 1'b0;
    chk_rd      = 1'b0;
    exp_rvalid  = 1'b0;
    exp_rdata   = '0;
    chk_wr      = 1'b0;
    exp_wgnt    = 1'b0;
    for (int r = 0; r < NrVregs; r++) begin
      for (int k = 0; k < NrElems; k++) begin
        model[r][k] = '0;
      end
    end
    repeat (10) @(posedge clk);
    #10;
    rst_ni = 1'b1;

    // Full writes followed by byte merges over them
    for (int a = 0; a < 32; a++) begin
      ext_write(vaddr_t'(a), next_rand(), 4'hf);
    end
    for (int a = 0; a < 32; a++) begin
      pick = next_rand();
      ext_write(vaddr_t'(a), next_rand(), pick[3:0]);
    end
    for (int a = 0; a < 32; a++) begin
      read_check(vaddr_t'(a));
    end

    // All legal opcodes at full length
    for (int op = 0; op < 6; op++) begin
      vd  = vreg_idx_t'(next_rand());
      vs1 = vreg_idx_t'(next_rand());
      vs2 = vreg_idx_t'(next_rand());
      // Distinct sources keep the operand order of vsub visible
      if (vs2 == vs1) begin
        vs2 = vs1 + vreg_idx_t'(1);
      end
      run_instr(3'(op), vd, vs1, vs2, 3'd4, 0, 1'b0);
      check_reg(vd);
    end

    // Partial lengths leave the upper elements alone
    for (int vl = 1; vl < 4; vl++) begin
      pick = next_rand() % 6;
      vd   = vreg_idx_t'(next_rand());
      vs1  = vreg_idx_t'(next_rand());
      vs2  = vreg_idx_t'(next_rand());
      run_instr(pick[2:0], vd, vs1, vs2, vl_t'(vl), 0, 1'b0);
      check_reg(vd);
    end

    // Requester holds req after ack before two illegal codes
    run_instr(3'd4, 3'd2, 3'd3, 3'd4, 3'd2, 3, 1'b0);
    run_instr(3'd6, 3'd5, 3'd1, 3'd2, 3'd4, 1, 1'b0);
    run_instr(3'd7, 3'd6, 3'd0, 3'd7, 3'd4, 1, 1'b0);
    check_all();

    // Bank conflicts while busy
    run_instr(3'd0, 3'd3, 3'd5, 3'd6, 3'd4, 0, 1'b1);
    check_all();

    $display("Checks issued: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== vec_bank.sv ====
////////////////////////////////////////
// Single register file bank, flip-flop
// storage with byte-enabled write
////////////////////////////////////////

`timescale 1ns/1ps

module vec_bank import vec_pkg::*; (
  input  logic      clk,
  input  logic      rst_ni,
  // Read ports
  input  vreg_idx_t raddr0_i,
  input  vreg_idx_t raddr1_i,
  output elem_t     rdata0_o,
  output elem_t     rdata1_o,
  // Write port
  input  logic      we_i,
  input  vreg_idx_t waddr_i,
  input  elem_t     wdata_i,
  input  be_t       wbe_i
);

  // One element of every vector register
  elem_t mem_q [NrVregs];

  always_ff @(posedge clk) begin
    if (!rst_ni) begin
      for (int r = 0; r < NrVregs; r++) begin
        mem_q[r] <= '0;
      end
    end else if (we_i) begin
      for (int b = 0; b < ElemBytes; b++) begin
        if (wbe_i[b]) begin
          mem_q[waddr_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // Reads see the stored value, no bypass
  assign rdata0_o = mem_q[raddr0_i];
  assign rdata1_o = mem_q[raddr1_i];

endmodule

// ==== vec_decode.sv ====
////////////////////////////////////////
// Instruction latch, opcode check and
// four-phase req/ack handshake FSM
////////////////////////////////////////

`timescale 1ns/1ps

module vec_decode import vec_pkg::*; (
  input  logic               clk,
  input  logic               rst_ni,
  // Instruction handshake
  input  logic               req_i,
  input  logic [OpWidth-1:0] op_i,
  input  vreg_idx_t          vd_i,
  input  vreg_idx_t          vs1_i,
  input  vreg_idx_t          vs2_i,
  input  vl_t                vl_i,
  output logic               ack_o,
  // Execute side
  input  logic               done_i,
  output logic               start_o,
  output vec_op_e            op_o,
  output vreg_idx_t          vd_o,
  output vreg_idx_t          vs1_o,
  output vreg_idx_t          vs2_o,
  output vl_t                vl_o
);

  dec_state_e state_q, state_d;
  logic       accept;
  logic       op_legal;
  logic       legal_q;
  logic       start_q;

  assign accept   = (state_q == IDLE) && req_i;
  assign op_legal = (op_i <= OP_VMUL);

  // Illegal ops still spend one BUSY cycle before ACK
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (req_i) state_d = BUSY;
      BUSY:    if (done_i || !legal_q) state_d = ACK;
      ACK:     if (!req_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      legal_q <= 1'b0;
      start_q <= 1'b0;
    end else begin
      state_q <= state_d;
      start_q <= accept && op_legal;
      if (accept) begin
        legal_q <= op_legal;
      end
    end
  end

  // Instruction fields, held while busy
  always_ff @(posedge clk) begin
    if (accept) begin
      op_o  <= vec_op_e'(op_i);
      vd_o  <= vd_i;
      vs1_o <= vs1_i;
      vs2_o <= vs2_i;
      vl_o  <= vl_i;
    end
  end

  assign start_o = start_q;
  assign ack_o   = (state_q == ACK);

endmodule

// ==== vec_execute.sv ====
////////////////////////////////////////
// Element sequencer and ALU, one element
// pair read and computed per cycle
////////////////////////////////////////

`timescale 1ns/1ps

module vec_execute import vec_pkg::*; (
  input  logic      clk,
  input  logic      rst_ni,
  input  logic      start_i,
  input  vec_op_e   op_i,
  input  vreg_idx_t vs1_i,
  input  vreg_idx_t vs2_i,
  input  vreg_idx_t vd_i,
  input  vl_t       vl_i,
  // Operand reads
  output logic      vs1_re_o,
  output vaddr_t    vs1_raddr_o,
  output logic      vs2_re_o,
  output vaddr_t    vs2_raddr_o,
  input  elem_t     vs1_rdata_i,
  input  elem_t     vs2_rdata_i,
  // Registered result
  output logic      res_valid_o,
  output vaddr_t    res_addr_o,
  output elem_t     res_data_o,
  output logic      res_last_o
);

  logic      active_q;
  elem_idx_t idx_q;
  logic      last_elem;
  elem_t     alu_res;

  // Also stops at the top slot for an out of range vl
  assign last_elem = (idx_q == elem_idx_t'(NrElems - 1)) ||
                     (vl_t'(idx_q) + vl_t'(1) >= vl_i);

  always_ff @(posedge clk) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      idx_q    <= '0;
    end else if (start_i) begin
      active_q <= 1'b1;
      idx_q    <= '0;
    end else if (active_q) begin
      active_q <= !last_elem;
      idx_q    <= idx_q + elem_idx_t'(1);
    end
  end

  assign vs1_re_o    = active_q;
  assign vs2_re_o    = active_q;
  assign vs1_raddr_o = {vs1_i, idx_q};
  assign vs2_raddr_o = {vs2_i, idx_q};

  // vs2 is the left operand
  always_comb begin
    case (op_i)
      OP_VADD: alu_res = vs2_rdata_i + vs1_rdata_i;
      OP_VSUB: alu_res = vs2_rdata_i - vs1_rdata_i;
      OP_VAND: alu_res = vs2_rdata_i & vs1_rdata_i;
      OP_VOR:  alu_res = vs2_rdata_i | vs1_rdata_i;
      OP_VXOR: alu_res = vs2_rdata_i ^ vs1_rdata_i;
      OP_VMUL: alu_res = vs2_rdata_i * vs1_rdata_i;
      default: alu_res = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_ni) begin
      res_valid_o <= 1'b0;
      res_last_o  <= 1'b0;
    end else begin
      res_valid_o <= active_q;
      res_last_o  <= active_q && last_elem;
    end
  end

  always_ff @(posedge clk) begin
    res_addr_o <= {vd_i, idx_q};
    res_data_o <= alu_res;
  end

endmodule

// ==== vec_pkg.sv ====
////////////////////////////////////////
// Shared sizes, element address split,
// opcode and decode state encodings for
// the vector execution slice
////////////////////////////////////////

package vec_pkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////

  localparam int unsigned NrVregs   = 8;
  localparam int unsigned NrElems   = 4;
  localparam int unsigned ElemWidth = 32;
  localparam int unsigned ElemBytes = ElemWidth / 8;
  // One bank per element slot
  localparam int unsigned NrBanks   = NrElems;

  localparam int unsigned VregIdxWidth = $clog2(NrVregs);
  localparam int unsigned ElemIdxWidth = $clog2(NrElems);
  localparam int unsigned VaddrWidth   = VregIdxWidth + ElemIdxWidth;
  localparam int unsigned VlWidth      = ElemIdxWidth + 1;
  localparam int unsigned OpWidth      = 3;

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  typedef logic [VregIdxWidth-1:0] vreg_idx_t;
  typedef logic [ElemIdxWidth-1:0] elem_idx_t;
  // Register index on top, element (bank) index below
  typedef logic [VaddrWidth-1:0]   vaddr_t;
  typedef logic [ElemWidth-1:0]    elem_t;
  typedef logic [ElemBytes-1:0]    be_t;
  typedef logic [VlWidth-1:0]      vl_t;

  // Codes 6 and 7 are not assigned
  typedef enum logic [OpWidth-1:0] {
    OP_VADD = 3'd0,
    OP_VSUB = 3'd1,
    OP_VAND = 3'd2,
    OP_VOR  = 3'd3,
    OP_VXOR = 3'd4,
    OP_VMUL = 3'd5
  } vec_op_e;

  typedef enum logic [1:0] {
    IDLE = 2'd0,
    BUSY = 2'd1,
    ACK  = 2'd2
  } dec_state_e;

endpackage

// ==== vec_result.sv ====
////////////////////////////////////////
// Writeback of computed elements and
// completion pulse
////////////////////////////////////////

`timescale 1ns/1ps

module vec_result import vec_pkg::*; (
  input  logic   clk,
  input  logic   rst_ni,
  // From execute
  input  logic   res_valid_i,
  input  vaddr_t res_addr_i,
  input  elem_t  res_data_i,
  input  logic   res_last_i,
  // Register file write port 0
  output logic   we_o,
  output vaddr_t waddr_o,
  output elem_t  wdata_o,
  // To decode
  output logic   done_o
);

  logic done_q;

  // Write goes out in the cycle the result is held
  assign we_o    = res_valid_i;
  assign waddr_o = res_addr_i;
  assign wdata_o = res_valid_i ? res_data_i : '0;

  // Last element lands at the edge that raises done
  always_ff @(posedge clk) begin
    if (!rst_ni) begin
      done_q <= 1'b0;
    end else begin
      done_q <= res_valid_i && res_last_i;
    end
  end

  assign done_o = done_q;

endmodule

// ==== vec_unit_top.sv ====
////////////////////////////////////////
// Vector unit top, decode, execute,
// writeback and register file
////////////////////////////////////////

`timescale 1ns/1ps

module vec_unit_top import vec_pkg::*; (
  input  logic               clk,
  input  logic               rst_ni,
  // Instruction handshake
  input  logic               req_i,
  output logic               ack_o,
  input  logic [OpWidth-1:0] op_i,
  input  vreg_idx_t          vd_i,
  input  vreg_idx_t          vs1_i,
  input  vreg_idx_t          vs2_i,
  input  vl_t                vl_i,
  // External element write
  input  logic               ext_we_i,
  input  vaddr_t             ext_waddr_i,
  input  elem_t              ext_wdata_i,
  input  be_t                ext_wbe_i,
  output logic               ext_wgnt_o,
  // External element read
  input  logic               ext_re_i,
  input  vaddr_t             ext_raddr_i,
  output elem_t              ext_rdata_o,
  output logic               ext_rvalid_o
);

  // Decode to execute
  logic      start;
  vec_op_e   dec_op;
  vreg_idx_t dec_vd;
  vreg_idx_t dec_vs1;
  vreg_idx_t dec_vs2;
  vl_t       dec_vl;
  logic      done;

  // Operand reads
  logic      vs1_re;
  vaddr_t    vs1_raddr;
  elem_t     vs1_rdata;
  logic      vs2_re;
  vaddr_t    vs2_raddr;
  elem_t     vs2_rdata;

  // Execute to writeback
  logic      res_valid;
  vaddr_t    res_addr;
  elem_t     res_data;
  logic      res_last;
  logic      res_we;
  vaddr_t    res_waddr;
  elem_t     res_wdata;

  vec_decode i_decode (
    .clk     (clk),
    .rst_ni  (rst_ni),
    .req_i   (req_i),
    .op_i    (op_i),
    .vd_i    (vd_i),
    .vs1_i   (vs1_i),
    .vs2_i   (vs2_i),
    .vl_i    (vl_i),
    .ack_o   (ack_o),
    .done_i  (done),
    .start_o (start),
    .op_o    (dec_op),
    .vd_o    (dec_vd),
    .vs1_o   (dec_vs1),
    .vs2_o   (dec_vs2),
    .vl_o    (dec_vl)
  );

  vec_execute i_execute (
    .clk         (clk),
    .rst_ni      (rst_ni),
    .start_i     (start),
    .op_i        (dec_op),
    .vs1_i       (dec_vs1),
    .vs2_i       (dec_vs2),
    .vd_i        (dec_vd),
    .vl_i        (dec_vl),
    .vs1_re_o    (vs1_re),
    .vs1_raddr_o (vs1_raddr),
    .vs2_re_o    (vs2_re),
    .vs2_raddr_o (vs2_raddr),
    .vs1_rdata_i (vs1_rdata),
    .vs2_rdata_i (vs2_rdata),
    .res_valid_o (res_valid),
    .res_addr_o  (res_addr),
    .res_data_o  (res_data),
    .res_last_o  (res_last)
  );

  vec_result i_result (
    .clk         (clk),
    .rst_ni      (rst_ni),
    .res_valid_i (res_valid),
    .res_addr_i  (res_addr),
    .res_data_i  (res_data),
    .res_last_i  (res_last),
    .we_o        (res_we),
    .waddr_o     (res_waddr),
    .wdata_o     (res_wdata),
    .done_o      (done)
  );

  vec_vrf i_vrf (
    .clk          (clk),
    .rst_ni       (rst_ni),
    .res_we_i     (res_we),
    .res_waddr_i  (res_waddr),
    .res_wdata_i  (res_wdata),
    .ext_we_i     (ext_we_i),
    .ext_waddr_i  (ext_waddr_i),
    .ext_wdata_i  (ext_wdata_i),
    .ext_wbe_i    (ext_wbe_i),
    .ext_wgnt_o   (ext_wgnt_o),
    .vs2_re_i     (vs2_re),
    .vs2_raddr_i  (vs2_raddr),
    .vs2_rdata_o  (vs2_rdata),
    .vs1_re_i     (vs1_re),
    .vs1_raddr_i  (vs1_raddr),
    .vs1_rdata_o  (vs1_rdata),
    .ext_re_i     (ext_re_i),
    .ext_raddr_i  (ext_raddr_i),
    .ext_rdata_o  (ext_rdata_o),
    .ext_rvalid_o (ext_rvalid_o)
  );

endmodule

// ==== vec_vrf.sv ====
////////////////////////////////////////
// Banked vector register file, maps the
// result, operand and external ports
// onto four banks by fixed priority
////////////////////////////////////////

`timescale 1ns/1ps

module vec_vrf import vec_pkg::*; (
  input  logic   clk,
  input  logic   rst_ni,
  // Result write, highest priority
  input  logic   res_we_i,
  input  vaddr_t res_waddr_i,
  input  elem_t  res_wdata_i,
  // External write
  input  logic   ext_we_i,
  input  vaddr_t ext_waddr_i,
  input  elem_t  ext_wdata_i,
  input  be_t    ext_wbe_i,
  output logic   ext_wgnt_o,
  // Operand reads
  input  logic   vs2_re_i,
  input  vaddr_t vs2_raddr_i,
  output elem_t  vs2_rdata_o,
  input  logic   vs1_re_i,
  input  vaddr_t vs1_raddr_i,
  output elem_t  vs1_rdata_o,
  // External read, shares bank port 1 with vs1
  input  logic   ext_re_i,
  input  vaddr_t ext_raddr_i,
  output elem_t  ext_rdata_o,
  output logic   ext_rvalid_o
);

  // Bank number from the low address bits
  function automatic elem_idx_t bank_of(vaddr_t addr);
    return addr[ElemIdxWidth-1:0];
  endfunction

  // Register index inside a bank
  function automatic vreg_idx_t row_of(vaddr_t addr);
    return addr[VaddrWidth-1:ElemIdxWidth];
  endfunction

  vreg_idx_t [NrBanks-1:0] bank_raddr0;
  vreg_idx_t [NrBanks-1:0] bank_raddr1;
  elem_t     [NrBanks-1:0] bank_rdata0;
  elem_t     [NrBanks-1:0] bank_rdata1;
  logic      [NrBanks-1:0] bank_we;
  vreg_idx_t [NrBanks-1:0] bank_waddr;
  elem_t     [NrBanks-1:0] bank_wdata;
  be_t       [NrBanks-1:0] bank_wbe;

  ////////////////////////////////////////
  // Write mapping
  ////////////////////////////////////////

  always_comb begin
    bank_we    = '0;
    bank_waddr = '0;
    bank_wdata = '0;
    bank_wbe   = '0;
    ext_wgnt_o = 1'b0;
    for (int i = 0; i < NrBanks; i++) begin
      if (res_we_i && bank_of(res_waddr_i) == elem_idx_t'(i)) begin
        bank_we[i]    = 1'b1;
        bank_waddr[i] = row_of(res_waddr_i);
        bank_wdata[i] = res_wdata_i;
        bank_wbe[i]   = '1;
      end else if (ext_we_i && bank_of(ext_waddr_i) == elem_idx_t'(i)) begin
        bank_we[i]    = 1'b1;
        bank_waddr[i] = row_of(ext_waddr_i);
        bank_wdata[i] = ext_wdata_i;
        bank_wbe[i]   = ext_wbe_i;
        ext_wgnt_o    = 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Read mapping
  ////////////////////////////////////////

  always_comb begin
    bank_raddr0  = '0;
    bank_raddr1  = '0;
    ext_rvalid_o = 1'b0;
    for (int i = 0; i < NrBanks; i++) begin
      // Port 0 only serves vs2
      if (vs2_re_i && bank_of(vs2_raddr_i) == elem_idx_t'(i)) begin
        bank_raddr0[i] = row_of(vs2_raddr_i);
      end
      // Port 1, vs1 ahead of the external reader
      if (vs1_re_i && bank_of(vs1_raddr_i) == elem_idx_t'(i)) begin
        bank_raddr1[i] = row_of(vs1_raddr_i);
      end else if (ext_re_i && bank_of(ext_raddr_i) == elem_idx_t'(i)) begin
        bank_raddr1[i] = row_of(ext_raddr_i);
        ext_rvalid_o   = 1'b1;
      end
    end
  end

  assign vs2_rdata_o = vs2_re_i ? bank_rdata0[bank_of(vs2_raddr_i)] : '0;
  assign vs1_rdata_o = vs1_re_i ? bank_rdata1[bank_of(vs1_raddr_i)] : '0;
  assign ext_rdata_o = ext_rvalid_o ? bank_rdata1[bank_of(ext_raddr_i)] : '0;

  ////////////////////////////////////////
  // Banks
  ////////////////////////////////////////

  for (genvar b = 0; b < NrBanks; b++) begin : gen_banks
    vec_bank i_bank (
      .clk      (clk),
      .rst_ni   (rst_ni),
      .raddr0_i (bank_raddr0[b]),
      .raddr1_i (bank_raddr1[b]),
      .rdata0_o (bank_rdata0[b]),
      .rdata1_o (bank_rdata1[b]),
      .we_i     (bank_we[b]),
      .waddr_i  (bank_waddr[b]),
      .wdata_i  (bank_wdata[b]),
      .wbe_i    (bank_wbe[b])
    );
  end

endmodule

// ==== vlog.f ====
vec_pkg.sv
vec_bank.sv
vec_vrf.sv
vec_decode.sv
vec_execute.sv
vec_result.sv
vec_unit_top.sv
tb_vec_unit.sv
